/* common/rfdc_timing_pkg.sv */
//--------------------------------------------------------------------------
// shared definitions for the rfdc timing-control subsystem
//   control-port request and response structs
//   register map constants and status codes
//   field views of the 32-bit register word, joined in one union
//--------------------------------------------------------------------------

package rfdc_timing_pkg;

  //--------------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------------

  // radio time, free running counter from the radio
  localparam int RADIO_TIME_W    = 64;
  // control-port address and data widths
  localparam int CTRLPORT_ADDR_W = 20;
  localparam int CTRLPORT_DATA_W = 32;

  //--------------------------------------------------------------------------
  // control-port transfer types
  //--------------------------------------------------------------------------

  // one request, wr and rd are single-cycle strobes
  typedef struct packed {
    logic                       wr;
    logic                       rd;
    logic [CTRLPORT_ADDR_W-1:0] addr;
    logic [CTRLPORT_DATA_W-1:0] data;
    // request waits for the timestamp when set
    logic                       has_time;
    // radio time at which the request takes effect
    logic [RADIO_TIME_W-1:0]    timestamp;
  } ctrlport_req_t;

  // one response, ack is a single-cycle pulse
  typedef struct packed {
    logic                       ack;
    logic [1:0]                 status;
    logic [CTRLPORT_DATA_W-1:0] data;
  } ctrlport_resp_t;

  // response status codes
  localparam logic [1:0] STS_OKAY = 2'b00;

  //--------------------------------------------------------------------------
  // register map
  //--------------------------------------------------------------------------

  localparam logic [CTRLPORT_ADDR_W-1:0] NCO_RESET_REG     = 20'h00000;
  localparam logic [CTRLPORT_ADDR_W-1:0] GEARBOX_RESET_REG = 20'h00004;

  // nco reset register
  // bit 0 starts the shared nco reset, bit 1 reads back the done level
  typedef struct packed {
    logic [29:0] unused;
    logic        nco_reset_done;
    logic        nco_reset_start;
  } nco_reset_fields_t;

  // gearbox reset register, both bits are write strobes
  typedef struct packed {
    logic [29:0] unused;
    logic        dac_reset;
    logic        adc_reset;
  } gearbox_reset_fields_t;

  // same 32-bit word, field layout picked by the address
  typedef union packed {
    nco_reset_fields_t     nco;
    gearbox_reset_fields_t gearbox;
  } rfdc_reg_word_u;

endpackage

/* rtl/ctrlport_timer.sv */
//--------------------------------------------------------------------------
// control-port timer
//   one-entry holding register for timed requests
//   releases each request as a single-cycle strobe once radio time
//   reaches its timestamp, untimed requests pass after one cycle
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module ctrlport_timer (
  input  logic                                     clk,
  input  logic                                     reset_i,
  input  logic [rfdc_timing_pkg::RADIO_TIME_W-1:0] radio_time_i,
  input  rfdc_timing_pkg::ctrlport_req_t           req_i,
  output rfdc_timing_pkg::ctrlport_req_t           req_o
);

  import rfdc_timing_pkg::*;

  // holding register
  ctrlport_req_t held_req;
  logic          held;

  // output stage, strobes kept apart from the payload
  ctrlport_req_t out_req;
  logic          out_wr;
  logic          out_rd;

  // decode of the incoming and the held request
  logic          in_strobe;
  logic          in_due;
  logic          held_due;
  logic          fire_in;

  //--------------------------------------------------------------------------
  // time compare
  //--------------------------------------------------------------------------

  assign in_strobe = req_i.wr | req_i.rd;
  // untimed, or timestamp already passed
  assign in_due    = !req_i.has_time || (req_i.timestamp <= radio_time_i);
  assign fire_in   = in_strobe && in_due;
  // held entry reaches its time
  assign held_due  = held && (held_req.timestamp <= radio_time_i);

  //--------------------------------------------------------------------------
  // control state
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset_i) begin
      held   <= 1'b0;
      out_wr <= 1'b0;
      out_rd <= 1'b0;
    end else begin
      // strobes last one cycle
      out_wr <= 1'b0;
      out_rd <= 1'b0;
      // held entry goes first
      if (held_due) begin
        out_wr <= held_req.wr;
        out_rd <= held_req.rd;
      end else if (fire_in) begin
        out_wr <= req_i.wr;
        out_rd <= req_i.rd;
      end
      // load a future request, or empty after release
      if (in_strobe && !in_due) begin
        held <= 1'b1;
      end else if (held_due) begin
        held <= 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------------
  // payload
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (in_strobe && !in_due) begin
      held_req <= req_i;
    end
    if (held_due) begin
      out_req <= held_req;
    end else if (fire_in) begin
      out_req <= req_i;
    end
  end

  // payload with the registered strobes on top
  always_comb begin
    req_o    = out_req;
    req_o.wr = out_wr;
    req_o.rd = out_rd;
  end

endmodule

/* rtl/rfdc_timing_regs.sv */
//--------------------------------------------------------------------------
// per-board register block
//   decodes the nco reset and gearbox reset registers
//   write strobes for nco start and gearbox pulses, ack and read data
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module rfdc_timing_regs (
  input  logic                            clk,
  input  logic                            reset_i,
  input  rfdc_timing_pkg::ctrlport_req_t  req_i,
  // already synchronized to clk
  input  logic                            nco_reset_done_i,
  output rfdc_timing_pkg::ctrlport_resp_t resp_o,
  output logic                            nco_start_o,
  output logic                            adc_reset_pulse_o,
  output logic                            dac_reset_pulse_o
);

  import rfdc_timing_pkg::*;

  // address decode
  logic           sel_nco;
  logic           sel_gearbox;
  logic           sel_any;

  // write data view and read data word
  rfdc_reg_word_u wr_word;
  rfdc_reg_word_u rd_word;
  rfdc_reg_word_u rd_word_q;
  logic           ack_q;

  //--------------------------------------------------------------------------
  // decode
  //--------------------------------------------------------------------------

  assign sel_nco     = (req_i.addr == NCO_RESET_REG);
  assign sel_gearbox = (req_i.addr == GEARBOX_RESET_REG);
  // unknown addresses give no ack at all
  assign sel_any     = sel_nco | sel_gearbox;
  assign wr_word     = req_i.data;

  // only the done bit is readable, gearbox reads as zero
  always_comb begin
    rd_word = '0;
    if (req_i.rd && sel_nco) begin
      rd_word.nco.nco_reset_done = nco_reset_done_i;
    end
  end

  //--------------------------------------------------------------------------
  // strobes and ack
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q             <= 1'b0;
      nco_start_o       <= 1'b0;
      adc_reset_pulse_o <= 1'b0;
      dac_reset_pulse_o <= 1'b0;
    end else begin
      ack_q             <= (req_i.wr | req_i.rd) & sel_any;
      // write strobes straight from the field view of the address
      nco_start_o       <= req_i.wr & sel_nco & wr_word.nco.nco_reset_start;
      adc_reset_pulse_o <= req_i.wr & sel_gearbox & wr_word.gearbox.adc_reset;
      dac_reset_pulse_o <= req_i.wr & sel_gearbox & wr_word.gearbox.dac_reset;
    end
  end

  // read data, only meaningful with ack
  always_ff @(posedge clk) begin
    rd_word_q <= rd_word;
  end

  always_comb begin
    resp_o        = '0;
    resp_o.ack    = ack_q;
    resp_o.status = STS_OKAY;
    resp_o.data   = rd_word_q;
  end

endmodule

/* rtl/nco_reset_merge.sv */
//--------------------------------------------------------------------------
// nco reset merge
//   one registered start pulse from all board start strobes
//   two-stage synchronizer for the done level from the converter
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module nco_reset_merge #(
  parameter int NUM_DBOARDS = 2
) (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic [NUM_DBOARDS-1:0] nco_start_i,
  // asynchronous level
  input  logic                   nco_reset_done_i,
  output logic                   start_nco_reset_o,
  output logic                   nco_reset_done_o
);

  // synchronizer stages
  logic done_meta;
  logic done_sync;

  //--------------------------------------------------------------------------
  // start merge
  //--------------------------------------------------------------------------

  // strobes in the same cycle from several boards give one pulse
  always_ff @(posedge clk) begin
    if (reset_i) begin
      start_nco_reset_o <= 1'b0;
    end else begin
      start_nco_reset_o <= |nco_start_i;
    end
  end

  //--------------------------------------------------------------------------
  // done synchronizer
  //--------------------------------------------------------------------------

  // level stays high until the next start, so two flops are enough
  always_ff @(posedge clk) begin
    if (reset_i) begin
      done_meta <= 1'b0;
      done_sync <= 1'b0;
    end else begin
      done_meta <= nco_reset_done_i;
      done_sync <= done_meta;
    end
  end

  assign nco_reset_done_o = done_sync;

endmodule

/* rtl/rfdc_timing_top.sv */
//--------------------------------------------------------------------------
// rfdc timing-control top level
//   one control-port timer and register block per board
//   shared nco start merge and done synchronizer
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module rfdc_timing_top #(
  // 1 to 4 boards
  parameter int NUM_DBOARDS = 2
) (
  input  logic                                                  clk,
  input  logic                                                  reset_i,
  input  logic [rfdc_timing_pkg::RADIO_TIME_W-1:0]              radio_time_i,
  // one control-port slave per board
  input  rfdc_timing_pkg::ctrlport_req_t  [NUM_DBOARDS-1:0]     ctrl_req_i,
  // asynchronous done level from the converter
  input  logic                                                  nco_reset_done_i,
  output rfdc_timing_pkg::ctrlport_resp_t [NUM_DBOARDS-1:0]     ctrl_resp_o,
  output logic                                                  start_nco_reset_o,
  output logic                            [NUM_DBOARDS-1:0]     adc_reset_pulse_o,
  output logic                            [NUM_DBOARDS-1:0]     dac_reset_pulse_o
);

  import rfdc_timing_pkg::*;

  // requests released by the timers
  ctrlport_req_t [NUM_DBOARDS-1:0] timed_req;
  // per-board start strobes into the merge
  logic          [NUM_DBOARDS-1:0] nco_start;
  // done level after the synchronizer
  logic                            nco_reset_done_sync;

  //--------------------------------------------------------------------------
  // per-board control ports
  //--------------------------------------------------------------------------

  for (genvar db = 0; db < NUM_DBOARDS; db++) begin : gen_db

    // input side, timed request hold
    ctrlport_timer i_ctrlport_timer (
      .clk          (clk),
      .reset_i      (reset_i),
      .radio_time_i (radio_time_i),
      .req_i        (ctrl_req_i[db]),
      .req_o        (timed_req[db])
    );

    // register decode for this board
    rfdc_timing_regs i_rfdc_timing_regs (
      .clk               (clk),
      .reset_i           (reset_i),
      .req_i             (timed_req[db]),
      .nco_reset_done_i  (nco_reset_done_sync),
      .resp_o            (ctrl_resp_o[db]),
      .nco_start_o       (nco_start[db]),
      .adc_reset_pulse_o (adc_reset_pulse_o[db]),
      .dac_reset_pulse_o (dac_reset_pulse_o[db])
    );

  end

  //--------------------------------------------------------------------------
  // shared nco reset
  //--------------------------------------------------------------------------

  nco_reset_merge #(
    .NUM_DBOARDS (NUM_DBOARDS)
  ) i_nco_reset_merge (
    .clk               (clk),
    .reset_i           (reset_i),
    .nco_start_i       (nco_start),
    .nco_reset_done_i  (nco_reset_done_i),
    .start_nco_reset_o (start_nco_reset_o),
    .nco_reset_done_o  (nco_reset_done_sync)
  );

endmodule

/* bench/rfdc_timing_sva.sv */
//--------------------------------------------------------------------------
// bound assertions on the rfdc timing-control top level
//   start pulse width, gearbox pulses with ack
//   no request while a timer holds one, quiet outputs in reset
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module rfdc_timing_sva #(
  parameter int NUM_DBOARDS = 2
) (
  input logic                                               clk,
  input logic                                               reset_i,
  input rfdc_timing_pkg::ctrlport_req_t  [NUM_DBOARDS-1:0]  ctrl_req_i,
  input rfdc_timing_pkg::ctrlport_resp_t [NUM_DBOARDS-1:0]  ctrl_resp_o,
  input logic                                               start_nco_reset_o,
  input logic                            [NUM_DBOARDS-1:0]  adc_reset_pulse_o,
  input logic                            [NUM_DBOARDS-1:0]  dac_reset_pulse_o
);

  // shared start is a single-cycle pulse
  assert property (@(posedge clk) disable iff (reset_i)
    start_nco_reset_o |=> !start_nco_reset_o)
    else $error("start_nco_reset_o high for more than one cycle");

  // shared outputs low in the cycle after a reset edge
  assert property (@(posedge clk)
    reset_i |=> !start_nco_reset_o && adc_reset_pulse_o == '0 && dac_reset_pulse_o == '0)
    else $error("start or gearbox pulse active during reset");

  for (genvar db = 0; db < NUM_DBOARDS; db++) begin : gen_chk

    // gearbox pulses only together with the board's ack
    assert property (@(posedge clk) disable iff (reset_i)
      (adc_reset_pulse_o[db] || dac_reset_pulse_o[db]) |-> ctrl_resp_o[db].ack)
      else $error("gearbox pulse without ack on board %0d", db);

    // timer has no back-pressure
    assert property (@(posedge clk) disable iff (reset_i)
      gen_db[db].i_ctrlport_timer.held |-> !(ctrl_req_i[db].wr || ctrl_req_i[db].rd))
      else $error("request on board %0d while its timer holds one", db);

    assert property (@(posedge clk)
      reset_i |=> !ctrl_resp_o[db].ack && !gen_db[db].i_ctrlport_timer.held)
      else $error("ack or held flag active during reset on board %0d", db);

  end

endmodule

bind rfdc_timing_top rfdc_timing_sva #(
  .NUM_DBOARDS (NUM_DBOARDS)
) i_rfdc_timing_sva (
  .clk               (clk),
  .reset_i           (reset_i),
  .ctrl_req_i        (ctrl_req_i),
  .ctrl_resp_o       (ctrl_resp_o),
  .start_nco_reset_o (start_nco_reset_o),
  .adc_reset_pulse_o (adc_reset_pulse_o),
  .dac_reset_pulse_o (dac_reset_pulse_o)
);

/* bench/rfdc_timing_tb.sv */
//--------------------------------------------------------------------------
// testbench for the rfdc timing-control top level
//   clock, reset, random control-port traffic from a fixed seed
//   reference model of the port timing, per-cycle checks
//   watchdog and closing summary
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module rfdc_timing_tb;

  import rfdc_timing_pkg::*;

  localparam int NUM_DBOARDS = 2;
  localparam int CLK_PERIOD  = 8;
  // transactions per test
  localparam int NUM_GB      = 40;
  localparam int NUM_NCO     = 20;
  localparam int NUM_RD      = 8;
  localparam int NUM_TIMED   = 20;
  localparam int NUM_UNK     = 20;
  // upper bound per transaction, longest timed delay plus window
  localparam int TXN_CYCLES  = 32;
  // read test costs about three transactions per round
  localparam int NUM_TXN     = NUM_GB + NUM_NCO + 3 * NUM_RD + NUM_TIMED + NUM_UNK;
  localparam int TIMEOUT_NS  = (NUM_TXN * TXN_CYCLES + 100) * CLK_PERIOD;

  logic                               clk;
  logic                               reset_i;
  logic [RADIO_TIME_W-1:0]            radio_time;
  ctrlport_req_t  [NUM_DBOARDS-1:0]   ctrl_req;
  logic                               nco_reset_done;
  ctrlport_resp_t [NUM_DBOARDS-1:0]   ctrl_resp;
  logic                               start_nco_reset;
  logic           [NUM_DBOARDS-1:0]   adc_pulse;
  logic           [NUM_DBOARDS-1:0]   dac_pulse;

  // staged requests for the next send
  ctrlport_req_t  [NUM_DBOARDS-1:0]   next_req;

  // expected response per board, -1 means none in the window
  int                                 exp_ack_c [NUM_DBOARDS];
  logic                               exp_adc   [NUM_DBOARDS];
  logic                               exp_dac   [NUM_DBOARDS];
  logic                               exp_rd    [NUM_DBOARDS];
  logic [31:0]                        exp_rdata [NUM_DBOARDS];
  int                                 exp_start_c;

  int                                 checks;
  int                                 errors;

  rfdc_timing_top #(
    .NUM_DBOARDS (NUM_DBOARDS)
  ) i_rfdc_timing_top (
    .clk               (clk),
    .reset_i           (reset_i),
    .radio_time_i      (radio_time),
    .ctrl_req_i        (ctrl_req),
    .nco_reset_done_i  (nco_reset_done),
    .ctrl_resp_o       (ctrl_resp),
    .start_nco_reset_o (start_nco_reset),
    .adc_reset_pulse_o (adc_pulse),
    .dac_reset_pulse_o (dac_pulse)
  );

  //--------------------------------------------------------------------------
  // clock and radio time
  //--------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // free running, one tick per clock
  always @(posedge clk) begin
    radio_time <= radio_time + 64'd1;
  end

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expv, input logic [31:0] actv);
    checks++;
    assert (actv === expv) else begin
      errors++;
      $display("mismatch %s %s expected %0h actual %0h", name, what, expv, actv);
    end
  endtask

  function automatic ctrlport_req_t make_req(input logic wr, input logic rd,
                                             input logic [19:0] addr,
                                             input logic [31:0] data);
    ctrlport_req_t req;
    req      = '0;
    req.wr   = wr;
    req.rd   = rd;
    req.addr = addr;
    req.data = data;
    return req;
  endfunction

  task automatic clear_expect();
    for (int b = 0; b < NUM_DBOARDS; b++) begin
      exp_ack_c[b] = -1;
      exp_adc[b]   = 1'b0;
      exp_dac[b]   = 1'b0;
      exp_rd[b]    = 1'b0;
      exp_rdata[b] = '0;
    end
    exp_start_c = -1;
    next_req    = '0;
  endtask

  // reference model, c_rel is the cycle in which the timer finds the request due
  task automatic expect_req(input int b, input ctrlport_req_t req, input int c_rel);
    rfdc_reg_word_u wr_view;
    rfdc_reg_word_u rd_view;
    logic           known;
    wr_view = req.data;
    rd_view = '0;
    known   = (req.addr == NCO_RESET_REG) || (req.addr == GEARBOX_RESET_REG);
    // ack two cycles after release, unknown addresses stay silent
    if ((req.wr || req.rd) && known) begin
      exp_ack_c[b] = c_rel + 2;
      exp_rd[b]    = req.rd;
    end
    if (req.rd && req.addr == NCO_RESET_REG) begin
      rd_view.nco.nco_reset_done = nco_reset_done;
    end
    exp_rdata[b] = rd_view;
    if (req.wr && req.addr == GEARBOX_RESET_REG) begin
      exp_adc[b] = wr_view.gearbox.adc_reset;
      exp_dac[b] = wr_view.gearbox.dac_reset;
    end
    // shared start one cycle behind the ack
    if (req.wr && req.addr == NCO_RESET_REG && wr_view.nco.nco_reset_start) begin
      exp_start_c = c_rel + 3;
    end
  endtask

  // strobe lasts exactly one cycle, next negedge is cycle 1
  task automatic send();
    @(posedge clk);
    ctrl_req <= next_req;
    @(posedge clk);
    ctrl_req <= '0;
  endtask

  // sampled on the falling edge, away from the driving edge
  task automatic check_window(input string name, input int n);
    logic e_ack;
    for (int c = 1; c <= n; c++) begin
      @(negedge clk);
      for (int b = 0; b < NUM_DBOARDS; b++) begin
        e_ack = (c == exp_ack_c[b]);
        check_value(name, $sformatf("board %0d ack cycle %0d", b, c),
                    32'(e_ack), 32'(ctrl_resp[b].ack));
        check_value(name, $sformatf("board %0d adc pulse cycle %0d", b, c),
                    32'(e_ack && exp_adc[b]), 32'(adc_pulse[b]));
        check_value(name, $sformatf("board %0d dac pulse cycle %0d", b, c),
                    32'(e_ack && exp_dac[b]), 32'(dac_pulse[b]));
        if (e_ack) begin
          check_value(name, $sformatf("board %0d status", b),
                      32'(STS_OKAY), 32'(ctrl_resp[b].status));
          if (exp_rd[b]) begin
            check_value(name, $sformatf("board %0d read data", b),
                        exp_rdata[b], ctrl_resp[b].data);
          end
        end
      end
      check_value(name, $sformatf("nco start cycle %0d", c),
                  32'(c == exp_start_c), 32'(start_nco_reset));
    end
  endtask

  //--------------------------------------------------------------------------
  // watchdog
  //--------------------------------------------------------------------------

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("error: watchdog timeout, tests did not finish within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------

  initial begin : main
    ctrlport_req_t           req;
    rfdc_reg_word_u          word;
    logic [RADIO_TIME_W-1:0] rt;
    logic [19:0]             addr;
    logic [1:0]              mask;
    logic                    rw;
    int                      b;
    int                      delta;
    int                      c_rel;
    void'($urandom(32'h16d7));
    checks         = 0;
    errors         = 0;
    reset_i        = 1'b1;
    ctrl_req       = '0;
    nco_reset_done = 1'b0;
    // high start value so the upper time bits take part
    radio_time     = {1'b0, 31'($urandom), $urandom};
    clear_expect();
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    // all quiet straight after reset
    check_window("after reset", 2);

    // gearbox writes on a random board
    for (int i = 0; i < NUM_GB; i++) begin
      clear_expect();
      b = int'($urandom_range(NUM_DBOARDS - 1, 0));
      next_req[b] = make_req(1'b1, 1'b0, GEARBOX_RESET_REG, $urandom);
      expect_req(b, next_req[b], 0);
      send();
      check_window("gearbox write", 6);
    end

    // nco start from one board or both in the same cycle
    for (int i = 0; i < NUM_NCO; i++) begin
      clear_expect();
      mask = 2'($urandom_range(3, 1));
      for (int d = 0; d < NUM_DBOARDS; d++) begin
        if (mask[d]) begin
          word                     = $urandom;
          word.nco.nco_reset_start = 1'($urandom_range(1, 0));
          next_req[d] = make_req(1'b1, 1'b0, NCO_RESET_REG, word);
          expect_req(d, next_req[d], 0);
        end
      end
      send();
      check_window("nco start", 6);
    end

    // done level read back through the synchronizer
    for (int i = 0; i < NUM_RD; i++) begin
      @(posedge clk);
      nco_reset_done <= 1'($urandom_range(1, 0));
      repeat (4) @(posedge clk);
      clear_expect();
      b = int'($urandom_range(NUM_DBOARDS - 1, 0));
      next_req[b] = make_req(1'b0, 1'b1, NCO_RESET_REG, $urandom);
      expect_req(b, next_req[b], 0);
      send();
      check_window("done read", 6);
      clear_expect();
      next_req[b] = make_req(1'b0, 1'b1, GEARBOX_RESET_REG, $urandom);
      expect_req(b, next_req[b], 0);
      send();
      check_window("gearbox read", 6);
    end

    // timed writes, future or already passed
    for (int i = 0; i < NUM_TIMED; i++) begin
      clear_expect();
      b = int'($urandom_range(NUM_DBOARDS - 1, 0));
      addr = ($urandom_range(1, 0) != 0) ? GEARBOX_RESET_REG : NCO_RESET_REG;
      req = make_req(1'b1, 1'b0, addr, $urandom);
      req.has_time = 1'b1;
      // time seen by the timer in cycle 0 is one above this
      @(negedge clk);
      rt = radio_time;
      if ($urandom_range(1, 0) != 0) begin
        delta         = int'($urandom_range(20, 0));
        req.timestamp = rt + 64'd1 + 64'(delta);
        c_rel         = delta;
      end else begin
        req.timestamp = rt + 64'd1 - 64'($urandom_range(500, 0));
        c_rel         = 0;
      end
      next_req[b] = req;
      expect_req(b, req, c_rel);
      send();
      check_window("timed write", c_rel + 6);
    end

    // reads and writes outside the register map
    for (int i = 0; i < NUM_UNK; i++) begin
      clear_expect();
      b    = int'($urandom_range(NUM_DBOARDS - 1, 0));
      addr = 20'($urandom);
      if (addr == NCO_RESET_REG || addr == GEARBOX_RESET_REG) begin
        addr = addr | 20'h8;
      end
      rw = 1'($urandom_range(1, 0));
      next_req[b] = make_req(rw, !rw, addr, $urandom);
      expect_req(b, next_req[b], 0);
      send();
      check_window("unknown address", 6);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* rfdc_timing_top.f */
common/rfdc_timing_pkg.sv
rtl/ctrlport_timer.sv
rtl/rfdc_timing_regs.sv
rtl/nco_reset_merge.sv
rtl/rfdc_timing_top.sv
bench/rfdc_timing_sva.sv
bench/rfdc_timing_tb.sv

/* Bender.yml */
package:
  name: rfdc_timing

sources:
  # package first, then the design bottom up
  - common/rfdc_timing_pkg.sv
  - rtl/ctrlport_timer.sv
  - rtl/rfdc_timing_regs.sv
  - rtl/nco_reset_merge.sv
  - rtl/rfdc_timing_top.sv

  # bound assertions and testbench
  - target: simulation
    files:
      - bench/rfdc_timing_sva.sv
      - bench/rfdc_timing_tb.sv
